// ==== design/zet_bus_defs.svh ====
`ifndef ZET_BUS_DEFS_SVH
`define ZET_BUS_DEFS_SVH

// CPU byte address and data widths.
`define ZET_ADR_W    20
`define ZET_DAT_W    16

// Word-wide RAM, 2**ZET_RAM_AW words, acked ZET_RAM_WAIT cycles after strobe.
`define ZET_RAM_AW   10
`define ZET_RAM_WAIT 2

// I/O register file, 2**ZET_IO_AW registers.
`define ZET_IO_AW    3

`endif

// ==== design/zet_bus_pkg.sv ====
package zet_bus_pkg;

  // A bus word, used whole or as two byte lanes.
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } b;
  } zet_word_u;

  // Bus master states.
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    STB1     = 2'd1,
    STB2     = 2'd2,
    BLOCK_LO = 2'd3
  } zet_mst_state_e;

endpackage

// ==== design/zet_wb_master.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_wb_master
  import zet_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  cpu_memop_i,
  input  logic                  cpu_m_io_i,
  input  logic [`ZET_ADR_W-1:0] cpu_adr_i,
  input  logic                  cpu_byte_i,
  input  logic                  cpu_we_i,
  input  logic [`ZET_DAT_W-1:0] cpu_dat_i,
  output logic [`ZET_DAT_W-1:0] cpu_dat_o,
  output logic                  cpu_block_o,
  input  logic [`ZET_DAT_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  output logic [`ZET_DAT_W-1:0] wb_dat_o,
  output logic [`ZET_ADR_W-1:1] wb_adr_o,
  output logic                  wb_we_o,
  output logic                  wb_tga_o,
  output logic [1:0]            wb_sel_o,
  output logic                  wb_stb_o,
  output logic                  wb_cyc_o
);

  zet_mst_state_e state;
  zet_mst_state_e state_nxt;
  zet_word_u      rd_word;
  zet_word_u      wr_word;
  zet_word_u      cpu_dat_q;
  logic           op;
  logic           odd_word;
  logic           a0;
  logic [1:0]     sel_first;

  assign op        = cpu_memop_i | cpu_m_io_i;
  assign a0        = cpu_adr_i[0];
  assign odd_word  = a0 & ~cpu_byte_i;
  assign sel_first = a0 ? 2'b10 : (cpu_byte_i ? 2'b01 : 2'b11);
  assign rd_word   = wb_dat_i;
  assign wr_word   = cpu_dat_i;

  assign wb_we_o   = cpu_we_i;
  assign wb_tga_o  = cpu_m_io_i;
  assign wb_cyc_o  = wb_stb_o;
  assign cpu_dat_o = cpu_dat_q.word;

  always_comb begin
    case (state)
      IDLE:     state_nxt = op ? STB1 : IDLE;
      STB1:     state_nxt = wb_ack_i ? (odd_word ? STB2 : BLOCK_LO) : STB1;
      STB2:     state_nxt = wb_ack_i ? BLOCK_LO : STB2;
      default:  state_nxt = IDLE;
    endcase
  end

  // The CPU is held from the request until the cycle after the last ack.
  always_comb begin
    case (state)
      IDLE:     cpu_block_o = op;
      BLOCK_LO: cpu_block_o = 1'b0;
      default:  cpu_block_o = 1'b1;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      state    <= IDLE;
      wb_stb_o <= 1'b0;
    end else begin
      state    <= state_nxt;
      wb_stb_o <= (state_nxt == STB1) || (state_nxt == STB2);
    end
  end

  // The second phase of an odd word reads or writes the low lane of the next word.
  always_ff @(posedge wb_clk_i) begin
    wb_adr_o <= (state_nxt == STB2) ? cpu_adr_i[`ZET_ADR_W-1:1] + 1'b1
                                    : cpu_adr_i[`ZET_ADR_W-1:1];
    wb_sel_o <= (state_nxt == STB2) ? 2'b01 : sel_first;
    wb_dat_o <= a0 ? {wr_word.b.lo, wr_word.b.hi} : wr_word.word;
  end

  always_ff @(posedge wb_clk_i) begin
    if (!cpu_we_i && wb_ack_i) begin
      if (state == STB1) begin
        if (a0) begin
          cpu_dat_q.word <= {{8{rd_word.b.hi[7]}}, rd_word.b.hi};
        end else if (cpu_byte_i) begin
          cpu_dat_q.word <= {{8{rd_word.b.lo[7]}}, rd_word.b.lo};
        end else begin
          cpu_dat_q.word <= rd_word.word;
        end
      end else if (state == STB2) begin
        cpu_dat_q.b.hi <= rd_word.b.lo;
      end
    end
  end

endmodule

// ==== design/zet_wb_router.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_wb_router (
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wb_tga_i,
  input  logic                  wb_stb_i,
  input  logic [`ZET_DAT_W-1:0] ram_dat_i,
  input  logic                  ram_ack_i,
  input  logic [`ZET_DAT_W-1:0] io_dat_i,
  input  logic                  io_ack_i,
  output logic                  ram_stb_o,
  output logic                  io_stb_o,
  output logic [`ZET_DAT_W-1:0] wb_dat_o,
  output logic                  wb_ack_o
);

  logic tga_q;
  logic io_sel;

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      tga_q <= 1'b0;
    end else if (wb_stb_i) begin
      tga_q <= wb_tga_i;
    end
  end

  // Outside a strobe the last target still owns the return path.
  assign io_sel    = wb_stb_i ? wb_tga_i : tga_q;
  assign ram_stb_o = wb_stb_i & ~wb_tga_i;
  assign io_stb_o  = wb_stb_i & wb_tga_i;
  assign wb_dat_o  = io_sel ? io_dat_i : ram_dat_i;
  assign wb_ack_o  = io_sel ? io_ack_i : ram_ack_i;

endmodule

// ==== design/zet_wb_ram.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_wb_ram
  import zet_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [1:0]            wb_sel_i,
  input  logic [`ZET_ADR_W-1:1] wb_adr_i,
  input  logic [`ZET_DAT_W-1:0] wb_dat_i,
  output logic [`ZET_DAT_W-1:0] wb_dat_o,
  output logic                  wb_ack_o
);

  localparam int CNT_W = $clog2(`ZET_RAM_WAIT + 1);

  zet_word_u               mem [0:(2**`ZET_RAM_AW)-1];
  zet_word_u               wr_word;
  logic [`ZET_RAM_AW-1:0]  idx;
  logic [CNT_W-1:0]        wait_cnt;

  assign idx     = wb_adr_i[`ZET_RAM_AW:1];
  assign wr_word = wb_dat_i;

  // Each address phase waits afresh, so the count restarts after an ack.
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      wait_cnt <= '0;
      wb_ack_o <= 1'b0;
    end else if (!wb_stb_i || wb_ack_o) begin
      wait_cnt <= '0;
      wb_ack_o <= 1'b0;
    end else if (wait_cnt == CNT_W'(`ZET_RAM_WAIT - 1)) begin
      wait_cnt <= '0;
      wb_ack_o <= 1'b1;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_stb_i && wb_ack_o && wb_we_i) begin
      if (wb_sel_i[0]) begin
        mem[idx].b.lo <= wr_word.b.lo;
      end
      if (wb_sel_i[1]) begin
        mem[idx].b.hi <= wr_word.b.hi;
      end
    end
    wb_dat_o <= mem[idx].word;
  end

endmodule

// ==== design/zet_io_regs.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_io_regs
  import zet_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [1:0]            wb_sel_i,
  input  logic [`ZET_ADR_W-1:1] wb_adr_i,
  input  logic [`ZET_DAT_W-1:0] wb_dat_i,
  output logic [`ZET_DAT_W-1:0] wb_dat_o,
  output logic                  wb_ack_o
);

  zet_word_u             regs [0:(2**`ZET_IO_AW)-1];
  zet_word_u             wr_word;
  logic [`ZET_IO_AW-1:0] idx;

  assign idx      = wb_adr_i[`ZET_IO_AW:1];
  assign wr_word  = wb_dat_i;
  assign wb_dat_o = regs[idx].word;

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      for (int i = 0; i < 2**`ZET_IO_AW; i++) begin
        regs[i].word <= '0;
      end
    end else begin
      // One ack per strobe phase, then a gap so a held strobe is seen as a new phase.
      wb_ack_o <= wb_stb_i & ~wb_ack_o;
      if (wb_stb_i && wb_ack_o && wb_we_i) begin
        if (wb_sel_i[0]) begin
          regs[idx].b.lo <= wr_word.b.lo;
        end
        if (wb_sel_i[1]) begin
          regs[idx].b.hi <= wr_word.b.hi;
        end
      end
    end
  end

endmodule

// ==== design/zet_mem_subsys.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_mem_subsys (
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  cpu_memop_i,
  input  logic                  cpu_m_io_i,
  input  logic [`ZET_ADR_W-1:0] cpu_adr_i,
  input  logic                  cpu_byte_i,
  input  logic                  cpu_we_i,
  input  logic [`ZET_DAT_W-1:0] cpu_dat_i,
  output logic [`ZET_DAT_W-1:0] cpu_dat_o,
  output logic                  cpu_block_o
);

  logic [`ZET_ADR_W-1:1] wb_adr;
  logic [`ZET_DAT_W-1:0] wb_dat_w;
  logic [`ZET_DAT_W-1:0] wb_dat_r;
  logic [`ZET_DAT_W-1:0] ram_dat;
  logic [`ZET_DAT_W-1:0] io_dat;
  logic [1:0]            wb_sel;
  logic                  wb_we;
  logic                  wb_tga;
  logic                  wb_stb;
  logic                  wb_ack;
  logic                  ram_stb;
  logic                  ram_ack;
  logic                  io_stb;
  logic                  io_ack;

  // Cycle mirrors strobe, so the slaves decode the strobe alone.
  zet_wb_master u_master (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .cpu_memop_i (cpu_memop_i),
    .cpu_m_io_i  (cpu_m_io_i),
    .cpu_adr_i   (cpu_adr_i),
    .cpu_byte_i  (cpu_byte_i),
    .cpu_we_i    (cpu_we_i),
    .cpu_dat_i   (cpu_dat_i),
    .cpu_dat_o   (cpu_dat_o),
    .cpu_block_o (cpu_block_o),
    .wb_dat_i    (wb_dat_r),
    .wb_ack_i    (wb_ack),
    .wb_dat_o    (wb_dat_w),
    .wb_adr_o    (wb_adr),
    .wb_we_o     (wb_we),
    .wb_tga_o    (wb_tga),
    .wb_sel_o    (wb_sel),
    .wb_stb_o    (wb_stb),
    .wb_cyc_o    ()
  );

  zet_wb_router u_router (
    .wb_clk_i  (wb_clk_i),
    .rst_n_i   (rst_n_i),
    .wb_tga_i  (wb_tga),
    .wb_stb_i  (wb_stb),
    .ram_dat_i (ram_dat),
    .ram_ack_i (ram_ack),
    .io_dat_i  (io_dat),
    .io_ack_i  (io_ack),
    .ram_stb_o (ram_stb),
    .io_stb_o  (io_stb),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack)
  );

  zet_wb_ram u_ram (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .wb_stb_i (ram_stb),
    .wb_we_i  (wb_we),
    .wb_sel_i (wb_sel),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (ram_dat),
    .wb_ack_o (ram_ack)
  );

  zet_io_regs u_io (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .wb_stb_i (io_stb),
    .wb_we_i  (wb_we),
    .wb_sel_i (wb_sel),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (io_dat),
    .wb_ack_o (io_ack)
  );

endmodule

// ==== test/zet_wb_chk.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_wb_chk
  import zet_bus_pkg::*;
(
  input logic                  wb_clk_i,
  input logic                  rst_n_i,
  input logic                  op_i,
  input logic                  cpu_block_i,
  input logic                  stb_i,
  input logic                  cyc_i,
  input logic                  ack_i,
  input logic [`ZET_ADR_W-1:1] adr_i,
  input logic [`ZET_DAT_W-1:0] dat_i,
  input logic [1:0]            sel_i,
  input zet_mst_state_e        state_i
);

  a_cyc_is_stb: assert property (@(posedge wb_clk_i) cyc_i == stb_i)
    else $error("wb_cyc_o differs from wb_stb_o");

  a_stb_after_reset: assert property (@(posedge wb_clk_i)
    !rst_n_i |=> (!stb_i && state_i == IDLE))
    else $error("master is not idle with wb_stb_o low right after reset");

  // The address phase holds until the slave acks it.
  a_phase_stable: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i) && $stable(sel_i)))
    else $error("bus address, data or select changed while waiting for ack");

  // A held request must see the stall again right after its release cycle.
  a_release_once: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (op_i && !cpu_block_i) |=> (!op_i || cpu_block_i))
    else $error("cpu_block_o stayed low for more than one cycle");

endmodule

// ==== test/zet_mem_monitor.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module zet_mem_monitor (
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_mem_i,
  input  logic                  req_io_i,
  input  logic [`ZET_ADR_W-1:0] adr_i,
  input  logic                  byte_i,
  input  logic                  we_i,
  input  logic [`ZET_DAT_W-1:0] wdat_i,
  input  logic [`ZET_DAT_W-1:0] rdat_i,
  input  logic                  block_i,
  output int                    done_cnt_o,
  output int                    err_cnt_o
);

  localparam int RAM_BYTES = 2 ** (`ZET_RAM_AW + 1);
  localparam int IO_BYTES  = 2 ** (`ZET_IO_AW + 1);

  // Byte-wide models, little-endian. RAM bytes are known only once written.
  logic [7:0] ram_b  [RAM_BYTES];
  bit         ram_ok [RAM_BYTES];
  logic [7:0] io_b   [IO_BYTES];
  int         grp_chk [4];
  int         grp_err [4];
  // Only the first low cycle of cpu_block_o counts as a completion.
  logic       block_q;

  function automatic logic [7:0] peek(input bit io, input int a);
    return io ? io_b[a] : ram_b[a];
  endfunction

  function automatic bit known(input bit io, input int a);
    return io || ram_ok[a];
  endfunction

  task automatic poke(input bit io, input int a, input logic [7:0] v);
    if (io) begin
      io_b[a] = v;
    end else begin
      ram_b[a]  = v;
      ram_ok[a] = 1'b1;
    end
  endtask

  // Group 0 counts aligned words, 1 bytes, 2 odd words and 3 the I/O space.
  always @(negedge wb_clk_i) begin : check_completion
    int          a0;
    int          a1;
    int          grp;
    logic [7:0]  b;
    logic [15:0] exp;
    logic [15:0] mask;
    if (!rst_n_i) begin
      done_cnt_o = 0;
      err_cnt_o  = 0;
      for (int i = 0; i < IO_BYTES; i++) begin
        io_b[i] = 8'h00;
      end
      for (int i = 0; i < RAM_BYTES; i++) begin
        ram_ok[i] = 1'b0;
      end
      for (int g = 0; g < 4; g++) begin
        grp_chk[g] = 0;
        grp_err[g] = 0;
      end
    end else if ((req_mem_i || req_io_i) && !block_i && block_q) begin
      done_cnt_o++;
      a0  = int'(adr_i) & (req_io_i ? IO_BYTES - 1 : RAM_BYTES - 1);
      a1  = (a0 + 1) & (req_io_i ? IO_BYTES - 1 : RAM_BYTES - 1);
      grp = req_io_i ? 3 : (byte_i ? 1 : (adr_i[0] ? 2 : 0));
      if (we_i) begin
        poke(req_io_i, a0, wdat_i[7:0]);
        if (!byte_i) begin
          poke(req_io_i, a1, wdat_i[15:8]);
        end
      end else begin
        grp_chk[grp]++;
        if (byte_i) begin
          b    = peek(req_io_i, a0);
          exp  = {{8{b[7]}}, b};
          mask = {16{known(req_io_i, a0)}};
        end else begin
          exp  = {peek(req_io_i, a1), peek(req_io_i, a0)};
          mask = {{8{known(req_io_i, a1)}}, {8{known(req_io_i, a0)}}};
        end
        if ((rdat_i & mask) !== (exp & mask)) begin
          $display("error cpu_dat_o adr=%h exp=%h got=%h", adr_i, exp & mask, rdat_i);
          grp_err[grp]++;
          err_cnt_o++;
        end
      end
    end
    block_q = block_i;
  end

endmodule

// ==== test/tb_zet_mem.sv ====
`timescale 1ns/10ps
`include "zet_bus_defs.svh"

module tb_zet_mem;

  localparam int NUM_REQ     = 400;
  localparam int CYC_PER_REQ = 12;
  localparam int TIMEOUT_CYC = NUM_REQ * CYC_PER_REQ;
  localparam int RAM_BYTES   = 2 ** (`ZET_RAM_AW + 1);
  localparam int IO_BYTES    = 2 ** (`ZET_IO_AW + 1);

  logic                  wb_clk_i;
  logic                  rst_n_i;
  logic                  cpu_memop;
  logic                  cpu_m_io;
  logic [`ZET_ADR_W-1:0] cpu_adr;
  logic                  cpu_byte;
  logic                  cpu_we;
  logic [`ZET_DAT_W-1:0] cpu_dat_w;
  logic [`ZET_DAT_W-1:0] cpu_dat_r;
  logic                  cpu_block;
  int                    done_cnt;
  int                    err_cnt;
  int                    cyc_cnt;

  zet_mem_subsys u_dut (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .cpu_memop_i (cpu_memop),
    .cpu_m_io_i  (cpu_m_io),
    .cpu_adr_i   (cpu_adr),
    .cpu_byte_i  (cpu_byte),
    .cpu_we_i    (cpu_we),
    .cpu_dat_i   (cpu_dat_w),
    .cpu_dat_o   (cpu_dat_r),
    .cpu_block_o (cpu_block)
  );

  zet_mem_monitor u_mon (
    .wb_clk_i   (wb_clk_i),
    .rst_n_i    (rst_n_i),
    .req_mem_i  (cpu_memop),
    .req_io_i   (cpu_m_io),
    .adr_i      (cpu_adr),
    .byte_i     (cpu_byte),
    .we_i       (cpu_we),
    .wdat_i     (cpu_dat_w),
    .rdat_i     (cpu_dat_r),
    .block_i    (cpu_block),
    .done_cnt_o (done_cnt),
    .err_cnt_o  (err_cnt)
  );

  bind zet_wb_master zet_wb_chk u_chk (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .op_i        (op),
    .cpu_block_i (cpu_block_o),
    .stb_i       (wb_stb_o),
    .cyc_i       (wb_cyc_o),
    .ack_i       (wb_ack_i),
    .adr_i       (wb_adr_o),
    .dat_i       (wb_dat_o),
    .sel_i       (wb_sel_o),
    .state_i     (state)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < TIMEOUT_CYC) begin
      @(posedge wb_clk_i);
      cyc_cnt++;
    end
    $display("timeout: %0d of %0d requests completed", done_cnt, NUM_REQ);
    $display("Test failures found");
    $finish;
  end

  // A third of the requests read back the previous location.
  task automatic drive_request(input int n);
    bit io;
    if (n > 0 && $urandom_range(0, 2) == 0) begin
      cpu_we <= 1'b0;
    end else begin
      io = ($urandom_range(0, 3) == 0);
      cpu_memop <= !io;
      cpu_m_io  <= io;
      if (io) begin
        cpu_adr <= `ZET_ADR_W'($urandom_range(0, IO_BYTES - 1));
      end else begin
        // A window around address 0 also covers the wrap at the top of RAM.
        cpu_adr <= `ZET_ADR_W'(($urandom_range(0, 63) + RAM_BYTES - 32) % RAM_BYTES);
      end
      cpu_byte  <= 1'($urandom_range(0, 1));
      cpu_we    <= 1'($urandom_range(0, 1));
      cpu_dat_w <= 16'($urandom());
    end
  endtask

  task automatic wait_release();
    @(negedge wb_clk_i);
    while (cpu_block) begin
      @(negedge wb_clk_i);
    end
    @(posedge wb_clk_i);
  endtask

  task automatic print_report();
    string names [4] = '{"aligned word", "byte", "odd word", "io space"};
    for (int g = 0; g < 4; g++) begin
      $display("%s: reads %0d, errors %0d, %s", names[g], u_mon.grp_chk[g],
               u_mon.grp_err[g], (u_mon.grp_err[g] == 0) ? "ok" : "FAIL");
    end
    if (done_cnt != NUM_REQ) begin
      $display("completion count mismatch: %0d requests, %0d completions", NUM_REQ, done_cnt);
    end else begin
      $display("completion: %0d requests, %0d completions, ok", NUM_REQ, done_cnt);
    end
    $display("requests %0d, read errors %0d", NUM_REQ, err_cnt);
    if (err_cnt == 0 && done_cnt == NUM_REQ) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'h3dce));
    rst_n_i   = 1'b0;
    cpu_memop = 1'b0;
    cpu_m_io  = 1'b0;
    cpu_adr   = '0;
    cpu_byte  = 1'b0;
    cpu_we    = 1'b0;
    cpu_dat_w = '0;
    repeat (3) @(posedge wb_clk_i);
    rst_n_i <= 1'b1;
    @(posedge wb_clk_i);
    for (int n = 0; n < NUM_REQ; n++) begin
      drive_request(n);
      wait_release();
    end
    cpu_memop <= 1'b0;
    cpu_m_io  <= 1'b0;
    repeat (2) @(posedge wb_clk_i);
    print_report();
  end

endmodule

// ==== flist.f ====
+incdir+design
design/zet_bus_pkg.sv
design/zet_wb_master.sv
design/zet_wb_router.sv
design/zet_wb_ram.sv
design/zet_io_regs.sv
design/zet_mem_subsys.sv
test/zet_wb_chk.sv
test/zet_mem_monitor.sv
test/tb_zet_mem.sv

// ==== run.sh ====
#!/bin/sh
# Builds the memory bus testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_zet_mem -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
  exit 0
fi
exit 1
